// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := tb_icache
FLIST       := flist.f
BUILD_DIR   := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --timing --assert -j 0 -Mdir $(BUILD_DIR)
LINT_FLAGS  := --lint-only --timing
SIM_BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation ended without a result"; exit 1; }

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/icache_pkg.sv
src/line_ram.sv
src/tag_way.sv
src/way_arbiter.sv
src/refill_ctrl.sv
src/icache_ctrl.sv
src/icache_top.sv
test/tb_clock.sv
test/cbus_mem.sv
test/icache_assert.sv
test/tb_icache.sv

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  fetch_req,
    input  icache_pkg::addr_t     fetch_addr,
    output logic                  fetch_addr_ok,
    output logic                  fetch_data_ok,
    input  logic                  hit,
    input  icache_pkg::way_t      hit_way,
    input  icache_pkg::way_t      victim_way,
    input  icache_pkg::select_t   new_plru_bits,
    input  icache_pkg::select_t   plru_rdata,
    output logic                  plru_we,
    output icache_pkg::index_t    lookup_index,
    output icache_pkg::tag_t      lookup_tag,
    output icache_pkg::ram_addr_t ram_raddr,
    output logic                  refill_start,
    output icache_pkg::way_t      refill_way,
    input  logic                  fill_done,
    output logic                  fill_en,
    output icache_pkg::index_t    fill_index,
    output icache_pkg::tag_t      fill_tag
);

    logic             busy;
    logic             accept;
    icache_pkg::way_t fill_way;

    assign lookup_index = fetch_addr.index;
    assign lookup_tag   = fetch_addr.tag;

    // the held request misses until its tag is written
    assign accept = fetch_req && hit;

    assign fetch_addr_ok = accept;

    // data array read for the hit, data shows up next cycle
    assign ram_raddr = '{way: hit_way, index: fetch_addr.index, offset: fetch_addr.offset};

    // skip the PLRU write when nothing changes
    assign plru_we = accept && (new_plru_bits != plru_rdata);

    // only one refill in flight
    assign refill_start = fetch_req && !hit && !busy;

    // victim at start, latched way for the tag write
    assign refill_way = busy ? fill_way : victim_way;

    assign fill_en = fill_done;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy          <= 1'b0;
            fetch_data_ok <= 1'b0;
        end else begin
            fetch_data_ok <= accept;
            if (refill_start) begin
                busy <= 1'b1;
            end else if (fill_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start) begin
            fill_way   <= victim_way;
            fill_index <= fetch_addr.index;
            fill_tag   <= fetch_addr.tag;
        end
    end

endmodule

// ==== src/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 4;
    localparam int LINE_WORDS = 4;
    localparam int WORD_BITS  = 32;

    // address fields
    localparam int WAY_BITS    = $clog2(NUM_WAYS);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int BYTE_BITS   = 2;
    localparam int TAG_BITS    = WORD_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // data array depth, one entry per word of every line
    localparam int RAM_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    // payloads this narrow live in flops and are read without a register
    localparam int PASS_READ_MAX_BITS = 8;

    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [BYTE_BITS-1:0]   byte_t;
    typedef logic [WAY_BITS-1:0]    way_t;
    typedef logic [WORD_BITS-1:0]   data_t;

    // tree PLRU, bit 2 root, bit 1 leaf of ways 0/1, bit 0 leaf of ways 2/3
    typedef logic [NUM_WAYS-2:0] select_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        byte_t   zeros;
    } addr_t;

    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

endpackage

// ==== src/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              fetch_req,
    input  icache_pkg::addr_t fetch_addr,
    output logic              fetch_addr_ok,
    output logic              fetch_data_ok,
    output icache_pkg::data_t fetch_data,
    output logic              cbus_valid,
    output icache_pkg::addr_t cbus_addr,
    input  logic              cbus_okay,
    input  logic              cbus_last,
    input  icache_pkg::data_t cbus_rdata
);

    logic [icache_pkg::NUM_WAYS-1:0] hit_bits;
    logic                            hit;
    icache_pkg::way_t                hit_way;
    icache_pkg::way_t                victim_way;
    icache_pkg::select_t             new_plru_bits;
    icache_pkg::select_t             plru_rdata;
    logic                            plru_we;
    icache_pkg::index_t              lookup_index;
    icache_pkg::tag_t                lookup_tag;
    icache_pkg::ram_addr_t           ram_raddr;
    logic                            refill_start;
    icache_pkg::way_t                refill_way;
    logic                            fill_done;
    logic                            fill_en;
    icache_pkg::index_t              fill_index;
    icache_pkg::tag_t                fill_tag;
    logic                            ram_we;
    icache_pkg::ram_addr_t           ram_waddr;
    icache_pkg::data_t               ram_wdata;

    icache_ctrl i_icache_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_addr_ok (fetch_addr_ok),
        .fetch_data_ok (fetch_data_ok),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .new_plru_bits (new_plru_bits),
        .plru_rdata    (plru_rdata),
        .plru_we       (plru_we),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .ram_raddr     (ram_raddr),
        .refill_start  (refill_start),
        .refill_way    (refill_way),
        .fill_done     (fill_done),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag)
    );

    // one tag store per way, written only when it is the fill way
    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        tag_way i_tag_way (
            .clk          (clk),
            .resetn       (resetn),
            .lookup_index (lookup_index),
            .lookup_tag   (lookup_tag),
            .fill_en      (fill_en && (refill_way == icache_pkg::way_t'(w))),
            .fill_index   (fill_index),
            .fill_tag     (fill_tag),
            .hit_bit      (hit_bits[w])
        );
    end

    way_arbiter i_way_arbiter (
        .hit_bits      (hit_bits),
        .plru_bits     (plru_rdata),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .new_plru_bits (new_plru_bits)
    );

    refill_ctrl i_refill_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start      (refill_start),
        .line_addr  (fetch_addr),
        .victim_way (refill_way),
        .cbus_valid (cbus_valid),
        .cbus_addr  (cbus_addr),
        .cbus_okay  (cbus_okay),
        .cbus_last  (cbus_last),
        .cbus_rdata (cbus_rdata),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .fill_done  (fill_done)
    );

    line_ram #(
        .payload_t  (icache_pkg::data_t),
        .DEPTH_BITS (icache_pkg::RAM_ADDR_BITS)
    ) i_data_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (fetch_data)
    );

    // PLRU state per set, read in the lookup cycle
    line_ram #(
        .payload_t  (icache_pkg::select_t),
        .DEPTH_BITS (icache_pkg::INDEX_BITS)
    ) i_plru_ram (
        .clk   (clk),
        .we    (plru_we),
        .waddr (lookup_index),
        .wdata (new_plru_bits),
        .raddr (lookup_index),
        .rdata (plru_rdata)
    );

endmodule

// ==== src/line_ram.sv ====
`timescale 1ns/1ps

module line_ram #(
    parameter type payload_t  = logic [31:0],
    parameter int  DEPTH_BITS = 6
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] waddr,
    input  payload_t              wdata,
    input  logic [DEPTH_BITS-1:0] raddr,
    output payload_t              rdata
);

    payload_t mem [2**DEPTH_BITS];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < 2**DEPTH_BITS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    if ($bits(payload_t) <= icache_pkg::PASS_READ_MAX_BITS) begin : g_pass_read
        assign rdata = mem[raddr];
    end else begin : g_reg_read
        always_ff @(posedge clk) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== src/refill_ctrl.sv ====
`timescale 1ns/1ps

module refill_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  icache_pkg::addr_t     line_addr,
    input  icache_pkg::way_t      victim_way,
    output logic                  cbus_valid,
    output icache_pkg::addr_t     cbus_addr,
    input  logic                  cbus_okay,
    input  logic                  cbus_last,
    input  icache_pkg::data_t     cbus_rdata,
    output logic                  ram_we,
    output icache_pkg::ram_addr_t ram_waddr,
    output icache_pkg::data_t     ram_wdata,
    output logic                  fill_done
);

    logic                busy;
    logic                last_beat;
    icache_pkg::offset_t beat;
    icache_pkg::way_t    fill_way;
    icache_pkg::index_t  fill_index;
    icache_pkg::addr_t   base_addr;

    assign last_beat = busy && cbus_okay && cbus_last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy      <= 1'b0;
            beat      <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= last_beat;
            if (start && !busy) begin
                busy <= 1'b1;
                beat <= '0;
            end else if (busy && cbus_okay) begin
                beat <= beat + 1'b1;
                if (cbus_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // line-aligned burst address and target slot
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            fill_way         <= victim_way;
            fill_index       <= line_addr.index;
            base_addr.tag    <= line_addr.tag;
            base_addr.index  <= line_addr.index;
            base_addr.offset <= '0;
            base_addr.zeros  <= '0;
        end
    end

    assign cbus_valid = busy;
    assign cbus_addr  = base_addr;

    // each accepted beat lands at its word in the victim line
    assign ram_we    = busy && cbus_okay;
    assign ram_waddr = '{way: fill_way, index: fill_index, offset: beat};
    assign ram_wdata = cbus_rdata;

endmodule

// ==== src/tag_way.sv ====
`timescale 1ns/1ps

module tag_way (
    input  logic               clk,
    input  logic               resetn,
    input  icache_pkg::index_t lookup_index,
    input  icache_pkg::tag_t   lookup_tag,
    input  logic               fill_en,
    input  icache_pkg::index_t fill_index,
    input  icache_pkg::tag_t   fill_tag,
    output logic               hit_bit
);

    logic [icache_pkg::NUM_SETS-1:0] valid;
    icache_pkg::tag_t                tags [icache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_index] <= fill_tag;
        end
    end

    // compare against the stored tag of the looked-up set
    assign hit_bit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

endmodule

// ==== src/way_arbiter.sv ====
`timescale 1ns/1ps

module way_arbiter (
    input  logic [icache_pkg::NUM_WAYS-1:0] hit_bits,
    input  icache_pkg::select_t             plru_bits,
    output logic                            hit,
    output icache_pkg::way_t                hit_way,
    output icache_pkg::way_t                victim_way,
    output icache_pkg::select_t             new_plru_bits
);

    assign hit = |hit_bits;

    // at most one way matches, so a plain priority scan is enough
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
            if (hit_bits[i]) begin
                hit_way = icache_pkg::way_t'(i);
            end
        end
    end

    // walk the tree, zero goes left
    always_comb begin
        if (plru_bits[2]) begin
            victim_way = {1'b1, plru_bits[0]};
        end else begin
            victim_way = {1'b0, plru_bits[1]};
        end
    end

    // point the root and the hit way's leaf away from it
    always_comb begin
        new_plru_bits    = plru_bits;
        new_plru_bits[2] = ~hit_way[1];
        if (hit_way[1]) begin
            new_plru_bits[0] = ~hit_way[0];
        end else begin
            new_plru_bits[1] = ~hit_way[0];
        end
    end

endmodule

// ==== test/cbus_mem.sv ====
`timescale 1ns/1ps

module cbus_mem #(
    parameter int SEED     = 1,
    parameter int MAX_WAIT = 3
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              cbus_valid,
    input  icache_pkg::addr_t cbus_addr,
    output logic              cbus_okay,
    output logic              cbus_last,
    output icache_pkg::data_t cbus_rdata
);

    // low half is the word address, high half its inverse
    function automatic icache_pkg::data_t word_at(input logic [29:0] word_addr);
        return {~word_addr[15:0], word_addr[15:0]};
    endfunction

    // one process draws every wait state, so a single seed fixes the run
    initial begin : responder
        icache_pkg::offset_t beat;
        int                  wait_left;
        logic                done;
        void'($urandom(SEED));
        cbus_okay  = 1'b0;
        cbus_last  = 1'b0;
        cbus_rdata = '0;
        beat       = '0;
        done       = 1'b0;
        wait_left  = int'($urandom % (MAX_WAIT + 1));
        forever begin
            @(posedge clk);
            cbus_okay <= 1'b0;
            cbus_last <= 1'b0;
            if (resetn || !cbus_valid) begin
                beat = '0;
                done = 1'b0;
            end else if (!done) begin
                if (wait_left > 0) begin
                    wait_left = wait_left - 1;
                end else begin
                    cbus_okay  <= 1'b1;
                    cbus_rdata <= word_at({cbus_addr.tag, cbus_addr.index, beat});
                    // hold off after the fourth beat until valid drops
                    done = (beat == icache_pkg::offset_t'(icache_pkg::LINE_WORDS - 1));
                    cbus_last  <= done;
                    beat       = beat + 1'b1;
                    wait_left  = int'($urandom % (MAX_WAIT + 1));
                end
            end
        end
    end

endmodule

// ==== test/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert (
    input logic              clk,
    input logic              resetn,
    input logic              fetch_addr_ok,
    input logic              fetch_data_ok,
    input logic              cbus_valid,
    input icache_pkg::addr_t cbus_addr,
    input logic              cbus_okay,
    input logic              cbus_last
);

    int unsigned fail_count = 0;

    // burst stays up until the last beat is taken
    valid_held: assert property (@(posedge clk) disable iff (resetn)
        cbus_valid && !(cbus_okay && cbus_last) |=> cbus_valid)
        else begin
            fail_count++;
            $error("cbus_valid dropped before cbus_last");
        end

    data_after_accept: assert property (@(posedge clk) disable iff (resetn)
        fetch_addr_ok |=> fetch_data_ok)
        else begin
            fail_count++;
            $error("fetch_data_ok missing one cycle after fetch_addr_ok");
        end

    no_stray_data: assert property (@(posedge clk) disable iff (resetn)
        !fetch_addr_ok |=> !fetch_data_ok)
        else begin
            fail_count++;
            $error("fetch_data_ok without fetch_addr_ok in the cycle before");
        end

    line_aligned: assert property (@(posedge clk) disable iff (resetn)
        cbus_valid |-> (cbus_addr.offset == '0) && (cbus_addr.zeros == '0))
        else begin
            fail_count++;
            $error("cbus_addr is not line-aligned");
        end

endmodule

bind icache_top icache_assert i_icache_assert (
    .clk           (clk),
    .resetn        (resetn),
    .fetch_addr_ok (fetch_addr_ok),
    .fetch_data_ok (fetch_data_ok),
    .cbus_valid    (cbus_valid),
    .cbus_addr     (cbus_addr),
    .cbus_okay     (cbus_okay),
    .cbus_last     (cbus_last)
);

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

// ==== test/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int MAX_WAIT      = 3;
    localparam int RAND_SEED     = 4;
    localparam int NUM_ENTRIES   = 21;
    // worst refill with every beat at the longest wait, plus handshake slack
    localparam int ENTRY_CYCLES  = icache_pkg::LINE_WORDS * (MAX_WAIT + 1) + 12;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_ENTRIES * ENTRY_CYCLES) * CLK_PERIOD_NS;

    typedef struct packed {
        logic [31:0]       addr;
        icache_pkg::data_t data;
        logic              refill;
    } entry_t;

    // set 1 lines a..e at 0x4010 + 0x40 * n, expected data is {~wa[15:0], wa[15:0]}
    localparam entry_t STIM_TABLE [NUM_ENTRIES] = '{
        '{32'h0000_4010, 32'hEFFB_1004, 1'b1},  // a, cold miss, way 0
        '{32'h0000_4018, 32'hEFF9_1006, 1'b0},  // same line, other word
        '{32'h0000_4054, 32'hEFEA_1015, 1'b1},  // b, way 2
        '{32'h0000_4090, 32'hEFDB_1024, 1'b1},  // c, way 1
        '{32'h0000_40DC, 32'hEFC8_1037, 1'b1},  // d, way 3, plru back to 000
        '{32'h0000_4114, 32'hEFBA_1045, 1'b1},  // e evicts a from way 0
        '{32'h0000_40D4, 32'hEFCA_1035, 1'b0},  // d recently used
        '{32'h0000_401C, 32'hEFF8_1007, 1'b1},  // a again, evicts c from way 1
        '{32'h0000_4118, 32'hEFB9_1046, 1'b0},  // e still in way 0
        '{32'h0000_4098, 32'hEFD9_1026, 1'b1},  // c again, evicts b from way 2
        '{32'h0000_8000, 32'hDFFF_2000, 1'b1},  // set 0 warm-up
        '{32'h0000_8020, 32'hDFF7_2008, 1'b1},  // set 2 warm-up
        '{32'h0000_8030, 32'hDFF3_200C, 1'b1},  // set 3 warm-up
        '{32'h0000_8004, 32'hDFFE_2001, 1'b0},
        '{32'h0000_8028, 32'hDFF5_200A, 1'b0},
        '{32'h0000_803C, 32'hDFF0_200F, 1'b0},
        '{32'h0000_800C, 32'hDFFC_2003, 1'b0},
        '{32'h0000_8024, 32'hDFF6_2009, 1'b0},
        '{32'h0000_411C, 32'hEFB8_1047, 1'b0},  // e in set 1 survived
        '{32'hFFFF_FFF0, 32'h0003_FFFC, 1'b1},  // all-ones tag, set 3 way 2
        '{32'h0000_8034, 32'hDFF2_200D, 1'b0}
    };

    logic              clk;
    logic              resetn;
    logic              fetch_req;
    icache_pkg::addr_t fetch_addr;
    logic              fetch_addr_ok;
    logic              fetch_data_ok;
    icache_pkg::data_t fetch_data;
    logic              cbus_valid;
    icache_pkg::addr_t cbus_addr;
    logic              cbus_okay;
    logic              cbus_last;
    icache_pkg::data_t cbus_rdata;

    int   errors     = 0;
    int   passed     = 0;
    int   rise_count = 0;
    logic valid_seen = 1'b0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) i_tb_clock (.clk(clk));

    cbus_mem #(.SEED(RAND_SEED), .MAX_WAIT(MAX_WAIT)) i_cbus_mem (
        .clk        (clk),
        .resetn     (resetn),
        .cbus_valid (cbus_valid),
        .cbus_addr  (cbus_addr),
        .cbus_okay  (cbus_okay),
        .cbus_last  (cbus_last),
        .cbus_rdata (cbus_rdata)
    );

    icache_top i_icache_top (
        .clk           (clk),
        .resetn        (resetn),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_addr_ok (fetch_addr_ok),
        .fetch_data_ok (fetch_data_ok),
        .fetch_data    (fetch_data),
        .cbus_valid    (cbus_valid),
        .cbus_addr     (cbus_addr),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata)
    );

    // count burst starts on the cache bus
    always @(negedge clk) begin
        if (cbus_valid && !valid_seen) begin
            rise_count <= rise_count + 1;
        end
        valid_seen <= cbus_valid;
    end

    task automatic check_data(input int idx, input icache_pkg::data_t expected,
                              input icache_pkg::data_t actual);
        if (actual !== expected) begin
            $display("ERROR %0t: entry %0d fetch_data %08h, expected %08h",
                     $time, idx, actual, expected);
            errors++;
        end
    endtask

    task automatic check_refill(input int idx, input logic expected, input logic seen);
        if (seen !== expected) begin
            $display("ERROR %0t: entry %0d cache bus refill %0b, expected %0b",
                     $time, idx, seen, expected);
            errors++;
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("ERROR %0t: %s is %b after reset, expected 0", $time, name, value);
            errors++;
        end
    endtask

    task automatic fetch_entry(input int idx);
        entry_t ent;
        int     rise_before;
        int     errors_before;
        logic   refill_seen;
        ent           = STIM_TABLE[idx];
        errors_before = errors;
        @(posedge clk);
        rise_before = rise_count;
        fetch_req  <= 1'b1;
        fetch_addr <= icache_pkg::addr_t'(ent.addr);
        // hold the request until the cache takes it
        do begin
            @(negedge clk);
        end while (!fetch_addr_ok);
        @(posedge clk);
        fetch_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (!fetch_data_ok);
        refill_seen = (rise_count != rise_before);
        check_data(idx, ent.data, fetch_data);
        check_refill(idx, ent.refill, refill_seen);
        if (errors == errors_before) begin
            passed++;
        end
        $display("entry %0d: addr %08h data %08h refill %0b %s", idx, ent.addr,
                 fetch_data, refill_seen, (errors == errors_before) ? "ok" : "FAIL");
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int unsigned assert_fails;
        int          errors_before;
        resetn     = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        // resetn high holds the cache in reset
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        errors_before = errors;
        expect_low("fetch_addr_ok", fetch_addr_ok);
        expect_low("fetch_data_ok", fetch_data_ok);
        expect_low("cbus_valid", cbus_valid);
        if (errors == errors_before) begin
            passed++;
        end
        $display("reset: outputs low %s", (errors == errors_before) ? "ok" : "FAIL");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            fetch_entry(i);
        end
        assert_fails = i_icache_top.i_icache_assert.fail_count;
        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 NUM_ENTRIES + 1, passed, NUM_ENTRIES + 1 - passed, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
